// ==== common/cps_video_pkg.sv ====
package cps_video_pkg;

    // Screen geometry in pixels and lines
    localparam int H_TOTAL   = 512;
    localparam int H_VISIBLE = 384;
    localparam int HS_START  = 432;
    localparam int HS_END    = 463;

    localparam int V_TOTAL   = 262;
    localparam int V_VISIBLE = 224;
    localparam int VS_START  = 240;
    localparam int VS_END    = 242;

    // Mixer, palette read and brightness stages
    localparam int BLNK_DLY = 3;

    typedef logic [8:0]  hcnt_t;
    typedef logic [8:0]  vcnt_t;
    typedef logic [3:0]  nibble_t;
    typedef logic [7:0]  chan_t;

    // Palette number in the upper 5 bits, colour in the lower 4
    typedef logic [8:0]  layer_pxl_t;

    // 0 scroll 1, 1 scroll 2, 2 scroll 3, 3 objects
    typedef logic [1:0]  layer_id_t;

    typedef logic [10:0] pal_idx_t;

    // Brightness, red, green, blue from the top nibble down
    typedef logic [15:0] pal_entry_t;

    localparam nibble_t  COLOUR_TRANSP = 4'd15;
    localparam pal_idx_t BACKDROP_IDX  = '1;

endpackage

// ==== common/cps_regs_pkg.sv ====
package cps_regs_pkg;

    typedef logic [11:0] wb_adr_t;
    typedef logic [15:0] bus_data_t;
    typedef logic [1:0]  byte_sel_t;
    typedef logic [2:0]  reg_addr_t;

    // Address bit 11 selects the palette region
    localparam int PAL_SEL_BIT = 11;

    localparam reg_addr_t REG_LAYER_CTRL  = 3'd0;
    localparam reg_addr_t REG_RASTER_LINE = 3'd1;

    localparam bus_data_t LAYER_CTRL_RESET  = 16'd0;
    // Beyond the last line, so no match after reset
    localparam bus_data_t RASTER_LINE_RESET = 16'd511;

    // Layer enables sit above the four priority fields
    localparam int LC_EN_LSB = 8;

endpackage

// ==== common/cfg_bus_if.sv ====
interface cfg_bus_if;
    import cps_regs_pkg::*;

    wb_adr_t   cfg_addr;
    bus_data_t cfg_wdata;
    byte_sel_t cfg_sel;
    logic      reg_we;
    logic      pal_we;
    bus_data_t reg_rdata;

    modport ctrl (
        output cfg_addr,
        output cfg_wdata,
        output cfg_sel,
        output reg_we,
        output pal_we,
        input  reg_rdata
    );

    modport regs (
        input  reg_we,
        input  cfg_addr,
        input  cfg_wdata,
        input  cfg_sel,
        output reg_rdata
    );

    modport pal (
        input  pal_we,
        input  cfg_addr,
        input  cfg_wdata
    );

endinterface

// ==== hw/cps_bus_fsm.sv ====
module cps_bus_fsm (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  cps_regs_pkg::wb_adr_t   wb_adr,
    input  cps_regs_pkg::byte_sel_t wb_sel,
    input  cps_regs_pkg::bus_data_t wb_dat_w,
    output cps_regs_pkg::bus_data_t wb_dat_r,
    output logic                    wb_ack,
    cfg_bus_if.ctrl                 cfg
);
    import cps_regs_pkg::*;

    typedef enum logic {
        IDLE,
        ACK
    } bus_state_t;

    bus_state_t state;
    logic       req;
    logic       pal_sel;

    // New request only counts while idle
    assign req     = wb_cyc && wb_stb && (state == IDLE);
    assign pal_sel = wb_adr[PAL_SEL_BIT];

    assign cfg.cfg_addr  = wb_adr;
    assign cfg.cfg_wdata = wb_dat_w;
    assign cfg.cfg_sel   = wb_sel;
    assign cfg.reg_we    = req && wb_we && !pal_sel;
    assign cfg.pal_we    = req && wb_we && pal_sel;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: if (req) state <= ACK;
                ACK:  state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Palette is write-only, reads there return zero
    always_ff @(posedge clk) begin
        if (req) wb_dat_r <= pal_sel ? '0 : cfg.reg_rdata;
    end

    assign wb_ack = (state == ACK);

    a_ack_single: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack);

endmodule

// ==== hw/cps_timing.sv ====
module cps_timing (
    input  logic                 clk,
    input  logic                 rst,
    output cps_video_pkg::hcnt_t hdump,
    output cps_video_pkg::vcnt_t vdump,
    output logic                 hs,
    output logic                 vs,
    output logic                 hb,
    output logic                 vb
);
    import cps_video_pkg::*;

    hcnt_t h_nxt;
    vcnt_t v_nxt;
    logic  line_end;

    assign line_end = (hdump == hcnt_t'(H_TOTAL - 1));

    always_comb begin
        h_nxt = line_end ? '0 : hdump + 1'b1;
        v_nxt = vdump;
        if (line_end) begin
            v_nxt = (vdump == vcnt_t'(V_TOTAL - 1)) ? '0 : vdump + 1'b1;
        end
    end

    // Levels come from the next count so they line up with the counters
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hdump <= '0;
            vdump <= '0;
            hs    <= 1'b0;
            vs    <= 1'b0;
            hb    <= 1'b0;
            vb    <= 1'b0;
        end else begin
            hdump <= h_nxt;
            vdump <= v_nxt;
            hb    <= (h_nxt >= H_VISIBLE);
            vb    <= (v_nxt >= V_VISIBLE);
            hs    <= (h_nxt >= HS_START) && (h_nxt <= HS_END);
            vs    <= (v_nxt >= VS_START) && (v_nxt <= VS_END);
        end
    end

    a_cnt_range: assert property (
        @(posedge clk) disable iff (rst) (hdump < H_TOTAL) && (vdump < V_TOTAL)
    );

endmodule

// ==== hw/cps_mmr.sv ====
module cps_mmr (
    input  logic                    clk,
    input  logic                    rst,
    cfg_bus_if.regs                 cfg,
    input  cps_video_pkg::hcnt_t    hdump,
    input  cps_video_pkg::vcnt_t    vdump,
    output cps_regs_pkg::bus_data_t layer_ctrl,
    output logic                    raster
);
    import cps_video_pkg::*;
    import cps_regs_pkg::*;

    bus_data_t raster_line;
    reg_addr_t reg_sel;
    vcnt_t     next_line;

    function automatic bus_data_t merge_bytes(bus_data_t old, bus_data_t wdata, byte_sel_t sel);
        bus_data_t res;
        res = old;
        if (sel[0]) res[7:0] = wdata[7:0];
        if (sel[1]) res[15:8] = wdata[15:8];
        return res;
    endfunction

    assign reg_sel   = cfg.cfg_addr[2:0];
    assign next_line = (vdump == vcnt_t'(V_TOTAL - 1)) ? '0 : vdump + 1'b1;

    always_comb begin
        case (reg_sel)
            REG_LAYER_CTRL:  cfg.reg_rdata = layer_ctrl;
            REG_RASTER_LINE: cfg.reg_rdata = raster_line;
            default:         cfg.reg_rdata = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            layer_ctrl  <= LAYER_CTRL_RESET;
            raster_line <= RASTER_LINE_RESET;
            raster      <= 1'b0;
        end else begin
            if (cfg.reg_we && reg_sel == REG_LAYER_CTRL)
                layer_ctrl <= merge_bytes(layer_ctrl, cfg.cfg_wdata, cfg.cfg_sel);
            if (cfg.reg_we && reg_sel == REG_RASTER_LINE)
                raster_line <= merge_bytes(raster_line, cfg.cfg_wdata, cfg.cfg_sel);
            // Fires as the counters move to hdump 0 of the programmed line
            raster <= (hdump == hcnt_t'(H_TOTAL - 1)) && (bus_data_t'(next_line) == raster_line);
        end
    end

endmodule

// ==== colmix/cps_layer_mix.sv ====
module cps_layer_mix (
    input  logic                      clk,
    input  logic                      rst,
    input  cps_video_pkg::layer_pxl_t scr1_pxl,
    input  cps_video_pkg::layer_pxl_t scr2_pxl,
    input  cps_video_pkg::layer_pxl_t scr3_pxl,
    input  cps_video_pkg::layer_pxl_t obj_pxl,
    input  cps_regs_pkg::bus_data_t   layer_ctrl,
    output cps_video_pkg::pal_idx_t   pal_idx
);
    import cps_video_pkg::*;
    import cps_regs_pkg::*;

    layer_pxl_t pxl [4];
    pal_idx_t   mix_idx;

    // Indexed by layer id
    assign pxl[0] = scr1_pxl;
    assign pxl[1] = scr2_pxl;
    assign pxl[2] = scr3_pxl;
    assign pxl[3] = obj_pxl;

    // Walk from the lowest priority field up so the top field wins
    always_comb begin
        layer_id_t lid;
        mix_idx = BACKDROP_IDX;
        for (int k = 3; k >= 0; k--) begin
            lid = layer_id_t'(layer_ctrl[2*k +: 2]);
            if (layer_ctrl[LC_EN_LSB + int'(lid)] && pxl[lid][3:0] != COLOUR_TRANSP) begin
                mix_idx = {lid, pxl[lid]};
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pal_idx <= BACKDROP_IDX;
        end else begin
            pal_idx <= mix_idx;
        end
    end

endmodule

// ==== colmix/cps_pal.sv ====
module cps_pal (
    input  logic                    clk,
    input  logic                    rst,
    cfg_bus_if.pal                  cfg,
    input  cps_video_pkg::pal_idx_t pal_idx,
    input  logic                    hb,
    input  logic                    vb,
    output cps_video_pkg::chan_t    red,
    output cps_video_pkg::chan_t    green,
    output cps_video_pkg::chan_t    blue,
    output logic                    lhbl_dly,
    output logic                    lvbl_dly
);
    import cps_video_pkg::*;

    pal_entry_t pal_ram [2048];
    pal_entry_t pal_q;
    logic [BLNK_DLY-1:0] hbl_sr;
    logic [BLNK_DLY-1:0] vbl_sr;
    logic       visible;

    // Colour times brightness plus one, tops out at 240
    function automatic chan_t scale(nibble_t c, nibble_t b);
        return chan_t'(c) * (chan_t'(b) + 8'd1);
    endfunction

    // Whole word written, byte selects ignored
    always_ff @(posedge clk) begin
        if (cfg.pal_we) pal_ram[cfg.cfg_addr[10:0]] <= cfg.cfg_wdata;
        pal_q <= pal_ram[pal_idx];
    end

    // Value the delayed blanking takes on the same edge as the RGB stage
    assign visible = hbl_sr[BLNK_DLY-2] && vbl_sr[BLNK_DLY-2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hbl_sr <= '0;
            vbl_sr <= '0;
            red    <= '0;
            green  <= '0;
            blue   <= '0;
        end else begin
            hbl_sr <= {hbl_sr[BLNK_DLY-2:0], ~hb};
            vbl_sr <= {vbl_sr[BLNK_DLY-2:0], ~vb};
            red    <= visible ? scale(pal_q[11:8], pal_q[15:12]) : '0;
            green  <= visible ? scale(pal_q[7:4], pal_q[15:12]) : '0;
            blue   <= visible ? scale(pal_q[3:0], pal_q[15:12]) : '0;
        end
    end

    assign lhbl_dly = hbl_sr[BLNK_DLY-1];
    assign lvbl_dly = vbl_sr[BLNK_DLY-1];

endmodule

// ==== hw/cps_video.sv ====
module cps_video (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  cps_regs_pkg::wb_adr_t     wb_adr,
    input  cps_regs_pkg::byte_sel_t   wb_sel,
    input  cps_regs_pkg::bus_data_t   wb_dat_w,
    output cps_regs_pkg::bus_data_t   wb_dat_r,
    output logic                      wb_ack,
    input  cps_video_pkg::layer_pxl_t scr1_pxl,
    input  cps_video_pkg::layer_pxl_t scr2_pxl,
    input  cps_video_pkg::layer_pxl_t scr3_pxl,
    input  cps_video_pkg::layer_pxl_t obj_pxl,
    output cps_video_pkg::hcnt_t      hdump,
    output cps_video_pkg::vcnt_t      vdump,
    output logic                      hs,
    output logic                      vs,
    output logic                      hb,
    output logic                      vb,
    output logic                      lhbl_dly,
    output logic                      lvbl_dly,
    output cps_video_pkg::chan_t      red,
    output cps_video_pkg::chan_t      green,
    output cps_video_pkg::chan_t      blue,
    output logic                      raster
);
    import cps_video_pkg::*;
    import cps_regs_pkg::*;

    bus_data_t layer_ctrl;
    pal_idx_t  pal_idx;

    cfg_bus_if u_cfg ();

    cps_bus_fsm u_bus (.clk, .rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_sel,
                       .wb_dat_w, .wb_dat_r, .wb_ack, .cfg(u_cfg.ctrl));

    cps_timing u_timing (.clk, .rst, .hdump, .vdump, .hs, .vs, .hb, .vb);

    cps_mmr u_mmr (.clk, .rst, .cfg(u_cfg.regs), .hdump, .vdump, .layer_ctrl, .raster);

    cps_layer_mix u_mix (.clk, .rst, .scr1_pxl, .scr2_pxl, .scr3_pxl, .obj_pxl,
                         .layer_ctrl, .pal_idx);

    cps_pal u_pal (.clk, .rst, .cfg(u_cfg.pal), .pal_idx, .hb, .vb,
                   .red, .green, .blue, .lhbl_dly, .lvbl_dly);

endmodule

// ==== dv/tb_clk_gen.sv ====
module tb_clk_gen (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Held over the first two rising edges
    initial begin
        rst = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;
    end

endmodule

// ==== dv/tb_cps_video.sv ====
module tb_cps_video;
    import cps_video_pkg::*;
    import cps_regs_pkg::*;

    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    // Three frames of video plus room for the bus setup
    localparam int WATCHDOG_TIME = (3 * FRAME_CYCLES + 8192) * 10;

    typedef struct packed {
        logic  lh, lv;
        chan_t r, g, b;
    } pix_exp_t;

    logic       clk, rst;
    logic       wb_cyc, wb_stb, wb_we, wb_ack;
    wb_adr_t    wb_adr;
    byte_sel_t  wb_sel;
    bus_data_t  wb_dat_w, wb_dat_r;
    layer_pxl_t scr1_pxl, scr2_pxl, scr3_pxl, obj_pxl;
    hcnt_t      hdump, prev_h;
    vcnt_t      vdump, prev_v;
    logic       hs, vs, hb, vb, lhbl_dly, lvbl_dly, raster;
    chan_t      red, green, blue;

    integer     seed;
    bus_data_t  lc_model, rl_model, rdata;
    pal_entry_t pal_model [2048];
    pix_exp_t   exp_q [$];
    pix_exp_t   front;
    logic       timing_on, pix_on, have_prev;
    int         raster_cnt;

    tb_clk_gen u_clk_gen (.clk, .rst);

    cps_video i_dut (.clk, .rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_sel, .wb_dat_w,
                     .wb_dat_r, .wb_ack, .scr1_pxl, .scr2_pxl, .scr3_pxl, .obj_pxl, .hdump,
                     .vdump, .hs, .vs, .hb, .vb, .lhbl_dly, .lvbl_dly, .red, .green, .blue,
                     .raster);

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        abort_run($sformatf("ERROR time=%0t signal=%s expected=%0h actual=%0h",
                            $time, name, exp, act));
    endtask

    task automatic check_chan(input string name, input chan_t exp, input chan_t act);
        if (act !== exp) report_mismatch(name, 32'(exp), 32'(act));
    endtask

    task automatic check_data(input string name, input bus_data_t exp, input bus_data_t act);
        if (act !== exp) report_mismatch(name, 32'(exp), 32'(act));
    endtask

    task automatic check_cnt(input string name, input hcnt_t exp, input hcnt_t act);
        if (act !== exp) report_mismatch(name, 32'(exp), 32'(act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) report_mismatch(name, 32'(exp), 32'(act));
    endtask

    // One Wishbone classic cycle, ack due one clock after the request
    task automatic bus_cycle(input logic we, input wb_adr_t adr, input bus_data_t data,
                             input byte_sel_t sel);
        int waited;
        waited = 0;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_sel   = sel;
        wb_dat_w = data;
        do begin
            @(negedge clk);
            waited++;
            if (waited > 8) abort_run("Wishbone ack never arrived");
        end while (wb_ack !== 1'b1);
        if (waited != 1) abort_run($sformatf("Wishbone ack took %0d cycles", waited));
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic write_reg(input reg_addr_t r, input bus_data_t data, input byte_sel_t sel);
        bus_data_t mask;
        mask = {{8{sel[1]}}, {8{sel[0]}}};
        bus_cycle(1'b1, wb_adr_t'(r), data, sel);
        // Register took the value on the acked edge, model follows one edge later
        @(posedge clk);
        if (r == REG_LAYER_CTRL) lc_model = (lc_model & ~mask) | (data & mask);
        else rl_model = (rl_model & ~mask) | (data & mask);
    endtask

    task automatic check_reg(input reg_addr_t r);
        bus_cycle(1'b0, wb_adr_t'(r), '0, 2'b11);
        check_data("wb_dat_r", (r == REG_LAYER_CTRL) ? lc_model : rl_model, rdata);
    endtask

    task automatic wait_for_line(input vcnt_t line);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > FRAME_CYCLES) abort_run($sformatf("line %0d never came round", line));
        end while (!(vdump == line && hdump == '0));
    endtask

    function automatic layer_pxl_t rand_pixel();
        logic [31:0] r;
        r = $random(seed);
        // About a quarter forced transparent
        return (r[10:9] == 2'b00) ? {r[8:4], COLOUR_TRANSP} : r[8:0];
    endfunction

    // First enabled opaque layer in priority order, else backdrop
    function automatic pal_idx_t ref_index(input bus_data_t lc);
        layer_pxl_t px [4];
        layer_id_t  id;
        pal_idx_t   idx;
        logic       found;
        px    = '{scr1_pxl, scr2_pxl, scr3_pxl, obj_pxl};
        idx   = BACKDROP_IDX;
        found = 1'b0;
        for (int p = 0; p < 4; p++) begin
            id = lc[2*p +: 2];
            if (!found && lc[8 + id] && px[id][3:0] != COLOUR_TRANSP) begin
                idx   = {id, px[id]};
                found = 1'b1;
            end
        end
        return idx;
    endfunction

    function automatic pix_exp_t ref_pixel(input pal_idx_t idx, input logic hb_now,
                                           input logic vb_now);
        pix_exp_t   e;
        pal_entry_t ent;
        int         gain;
        ent  = pal_model[idx];
        gain = int'(ent[15:12]) + 1;
        e.lh = ~hb_now;
        e.lv = ~vb_now;
        e.r  = (hb_now || vb_now) ? '0 : chan_t'(int'(ent[11:8]) * gain);
        e.g  = (hb_now || vb_now) ? '0 : chan_t'(int'(ent[7:4]) * gain);
        e.b  = (hb_now || vb_now) ? '0 : chan_t'(int'(ent[3:0]) * gain);
        return e;
    endfunction

    always @(negedge clk) begin
        if (timing_on) begin
            if (have_prev) begin
                check_cnt("hdump", hcnt_t'((prev_h + 1) % H_TOTAL), hdump);
                check_cnt("vdump", (prev_h == hcnt_t'(H_TOTAL - 1)) ?
                          vcnt_t'((prev_v + 1) % V_TOTAL) : prev_v, vdump);
            end
            check_bit("hb", hdump >= H_VISIBLE, hb);
            check_bit("vb", vdump >= V_VISIBLE, vb);
            check_bit("hs", hdump >= HS_START && hdump <= HS_END, hs);
            check_bit("vs", vdump >= VS_START && vdump <= VS_END, vs);
            check_bit("raster", hdump == '0 && bus_data_t'(vdump) == rl_model, raster);
            if (raster) raster_cnt++;
            prev_h    = hdump;
            prev_v    = vdump;
            have_prev = 1'b1;
        end
        if (pix_on) begin
            if (exp_q.size() == BLNK_DLY) begin
                front = exp_q.pop_front();
                check_bit("lhbl_dly", front.lh, lhbl_dly);
                check_bit("lvbl_dly", front.lv, lvbl_dly);
                check_chan("red", front.r, red);
                check_chan("green", front.g, green);
                check_chan("blue", front.b, blue);
            end
            scr1_pxl = rand_pixel();
            scr2_pxl = rand_pixel();
            scr3_pxl = rand_pixel();
            obj_pxl  = rand_pixel();
            exp_q.push_back(ref_pixel(ref_index(lc_model), hb, vb));
        end
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Watchdog expired after three frames, the run timed out");
        $display("Simulation failed");
        $fatal(1, "timeout");
    end

    initial begin
        seed       = 32'h816f1c7e;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_sel     = '0;
        wb_dat_w   = '0;
        scr1_pxl   = '0;
        scr2_pxl   = '0;
        scr3_pxl   = '0;
        obj_pxl    = '0;
        timing_on  = 1'b0;
        pix_on     = 1'b0;
        have_prev  = 1'b0;
        raster_cnt = 0;
        lc_model   = LAYER_CTRL_RESET;
        rl_model   = RASTER_LINE_RESET;

        // Outputs while reset is held
        @(negedge clk);
        check_cnt("hdump", '0, hdump);
        check_cnt("vdump", '0, vdump);
        check_bit("hs", 1'b0, hs);
        check_bit("vs", 1'b0, vs);
        check_bit("raster", 1'b0, raster);
        check_bit("wb_ack", 1'b0, wb_ack);
        check_chan("red", '0, red);
        check_chan("green", '0, green);
        check_chan("blue", '0, blue);
        wait (rst == 1'b0);
        @(posedge clk);
        timing_on = 1'b1;

        check_reg(REG_LAYER_CTRL);
        check_reg(REG_RASTER_LINE);
        write_reg(REG_LAYER_CTRL, 16'ha5c3, 2'b01);
        check_reg(REG_LAYER_CTRL);
        write_reg(REG_LAYER_CTRL, 16'h5a3c, 2'b10);
        check_reg(REG_LAYER_CTRL);
        write_reg(REG_RASTER_LINE, 16'hff33, 2'b01);
        check_reg(REG_RASTER_LINE);
        write_reg(REG_RASTER_LINE, 16'h0000, 2'b10);
        check_reg(REG_RASTER_LINE);
        // Objects on top, then scroll 1, 2 and 3, all enabled
        write_reg(REG_LAYER_CTRL, 16'h0f93, 2'b11);
        check_reg(REG_LAYER_CTRL);

        // Byte selects low on purpose, the palette stores the whole word
        for (int i = 0; i < 2048; i++) begin
            pal_model[i] = 16'($random(seed));
            bus_cycle(1'b1, {1'b1, pal_idx_t'(i)}, pal_model[i], 2'b00);
        end
        // Low address bits here would select layer_ctrl in the register region
        bus_cycle(1'b0, 12'h800, '0, 2'b11);
        check_data("wb_dat_r", '0, rdata);

        wait_for_line(vcnt_t'(230));
        @(posedge clk);
        pix_on = 1'b1;

        // Scroll 3, objects, scroll 2, scroll 1 with scroll 2 disabled
        wait_for_line(vcnt_t'(230));
        write_reg(REG_LAYER_CTRL, 16'h0d1e, 2'b11);
        check_reg(REG_LAYER_CTRL);
        wait_for_line(vcnt_t'(230));

        if (raster_cnt >= 2) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("Raster interrupt fired only %0d times", raster_cnt);
            $display("Simulation failed");
            $fatal(1, "too few raster pulses");
        end
    end

endmodule

// ==== cps_video.f ====
common/cps_video_pkg.sv
common/cps_regs_pkg.sv
common/cfg_bus_if.sv
hw/cps_bus_fsm.sv
hw/cps_timing.sv
hw/cps_mmr.sv
colmix/cps_layer_mix.sv
colmix/cps_pal.sv
hw/cps_video.sv
dv/tb_clk_gen.sv
dv/tb_cps_video.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_cps_video \
    -f cps_video.f -o sim_cps_video > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_cps_video > sim.log 2>&1
grep -q "Simulation completed successfully" sim.log && echo "PASS" || { cat sim.log; echo "FAIL"; exit 1; }
